// ==== hw/id_params.svh ====
/* field positions, opcode encodings, condition codes and status bit positions of the decoder
   encodings are 7-bit values matched against instruction bits 31:25, don't-care bits are 0
   the S (flag-setting) bit is bit 28 of the word, bit 3 of the op field */
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define ID_OP_MSB   31              // op field top bit
`define ID_OP_LSB   25              // op field bottom bit
`define ID_S_BIT    28              // flag-setting bit of the ALU forms
`define ID_REG_W    3               // eight registers
`define ID_IMM_W    16              // immediate and branch offset width
`define ID_WORD_W   32

// memory and move
`define ID_ENC_LOAD   7'b1000000
`define ID_ENC_STOR   7'b1000001
`define ID_ENC_MOV    7'b0000000
`define ID_ENC_MOVT   7'b0000001
// alu with immediate operand
`define ID_ENC_ADD    7'b0010001
`define ID_ENC_ADDS   7'b0011001
`define ID_ENC_SUB    7'b0010010
`define ID_ENC_SUBS   7'b0011010
`define ID_ENC_AND    7'b0010011
`define ID_ENC_ANDS   7'b0011011
`define ID_ENC_OR     7'b0010100
`define ID_ENC_ORS    7'b0011100
`define ID_ENC_XOR    7'b0010101
`define ID_ENC_XORS   7'b0011101
// shifts and constant writes, done inside the decoder
`define ID_ENC_LSL    7'b0000100
`define ID_ENC_LSR    7'b0000101
`define ID_ENC_CLR    7'b0000010
`define ID_ENC_SET    7'b0000011
// alu with register operand
`define ID_ENC_ADD2   7'b0110001
`define ID_ENC_ADDS2  7'b0111001
`define ID_ENC_SUB2   7'b0110010
`define ID_ENC_SUBS2  7'b0111010
`define ID_ENC_AND2   7'b0110011
`define ID_ENC_ANDS2  7'b0111011
`define ID_ENC_OR2    7'b0110100
`define ID_ENC_ORS2   7'b0111100
`define ID_ENC_XOR2   7'b0110101
`define ID_ENC_XORS2  7'b0111101
`define ID_ENC_NOT    7'b0110110
// control flow
`define ID_ENC_B      7'b1100000
`define ID_ENC_BCOND  7'b1100001
`define ID_ENC_BR     7'b1100010
`define ID_ENC_NOP    7'b1100100
`define ID_ENC_HALT   7'b1101000

// branch conditions, bits 24:21
`define ID_COND_EQ    4'b0000
`define ID_COND_NE    4'b0001
`define ID_COND_CS    4'b0010
`define ID_COND_CC    4'b0011
`define ID_COND_MI    4'b0100
`define ID_COND_PL    4'b0101
`define ID_COND_VS    4'b0110
`define ID_COND_VC    4'b0111
`define ID_COND_HI    4'b1000
`define ID_COND_LS    4'b1001
`define ID_COND_GE    4'b1010
`define ID_COND_LT    4'b1011

`define ID_FLAG_N     31            // negative
`define ID_FLAG_Z     30            // zero
`define ID_FLAG_C     29            // carry
`define ID_FLAG_V     28            // overflow

`endif

// ==== hw/id_pkg.sv ====
/* shared types of the instruction decoder
   op_class_t needs 5 bits, seventeen classes do not fit in four */
package id_pkg;

`include "id_params.svh"

    typedef logic [`ID_WORD_W-1:0] word_t;      // data word
    typedef logic [`ID_REG_W-1:0]  reg_addr_t;  // register index

    typedef enum logic [3:0] {
        COND_EQ = `ID_COND_EQ,
        COND_NE = `ID_COND_NE,
        COND_CS = `ID_COND_CS,
        COND_CC = `ID_COND_CC,
        COND_MI = `ID_COND_MI,
        COND_PL = `ID_COND_PL,
        COND_VS = `ID_COND_VS,
        COND_VC = `ID_COND_VC,
        COND_HI = `ID_COND_HI,
        COND_LS = `ID_COND_LS,
        COND_GE = `ID_COND_GE,
        COND_LT = `ID_COND_LT
    } cond_t;                                   // codes 12..15 are unused, never taken

    // load and store layout
    typedef struct packed {
        logic [`ID_OP_MSB-`ID_OP_LSB:0] op;
        reg_addr_t                      rd;     // dest for load, source for store
        reg_addr_t                      ptr;    // pointer register
        logic [2:0]                     pad;
        logic [`ID_IMM_W-1:0]           imm;    // unsigned address offset
    } mem_fmt_t;

    // data processing layout
    typedef struct packed {
        logic [`ID_OP_MSB-`ID_OP_LSB:0] op;
        reg_addr_t                      rd;
        reg_addr_t                      op1;    // also the shifted register
        reg_addr_t                      op2;    // register forms only
        logic [`ID_IMM_W-1:0]           imm;
    } alu_fmt_t;

    // branch layout, BR takes its pointer from bits 24:22 via the mem view
    typedef struct packed {
        logic [`ID_OP_MSB-`ID_OP_LSB:0] op;
        cond_t                          cond;
        logic [4:0]                     pad;
        logic [`ID_IMM_W-1:0]           offset; // signed
    } br_fmt_t;

    typedef union packed {
        word_t    raw;
        mem_fmt_t mem;
        alu_fmt_t alu;
        br_fmt_t  br;
    } instr_u;

    typedef enum logic [4:0] {
        OPC_LOAD, OPC_STOR, OPC_MOV, OPC_MOVT,
        OPC_ALU_IMM, OPC_ALU_REG, OPC_NOT,
        OPC_LSL, OPC_LSR, OPC_CLR, OPC_SET,
        OPC_B, OPC_BCOND, OPC_BR,
        OPC_NOP, OPC_HALT, OPC_ILLEGAL
    } op_class_t;

endpackage

// ==== hw/id_cond_check.sv ====
/* branch condition check, purely combinational
   GE/LT compare N with Z as the processor defines them, codes 12..15 never branch */
`timescale 1ns/100ps

`include "id_params.svh"

module id_cond_check import id_pkg::*; (
    input  cond_t cond,             // condition field of the branch view
    input  word_t cpsr_val,         // status register as read
    output logic  branch_taken
);

    logic flag_n;
    logic flag_z;
    logic flag_c;
    logic flag_v;

    assign flag_n = cpsr_val[`ID_FLAG_N];
    assign flag_z = cpsr_val[`ID_FLAG_Z];
    assign flag_c = cpsr_val[`ID_FLAG_C];
    assign flag_v = cpsr_val[`ID_FLAG_V];

    always_comb begin
        case (cond)
            COND_EQ: branch_taken = flag_z;
            COND_NE: branch_taken = ~flag_z;
            COND_CS: branch_taken = flag_c;
            COND_CC: branch_taken = ~flag_c;
            COND_MI: branch_taken = flag_n;
            COND_PL: branch_taken = ~flag_n;
            COND_VS: branch_taken = flag_v;
            COND_VC: branch_taken = ~flag_v;
            COND_HI: branch_taken = ~flag_z & flag_c;       // unsigned higher
            COND_LS: branch_taken = ~(~flag_z & flag_c);    // not higher
            COND_GE: branch_taken = (flag_n == flag_z);
            COND_LT: branch_taken = (flag_n != flag_z);
            default: branch_taken = 1'b0;                   // reserved codes
        endcase
    end

endmodule

// ==== hw/id_ctrl_decode.sv ====
/* control side of the decoder, classifies the op field and drives strobes and addresses
   halt_flag is registered, set by HALT, cleared only by arst_n; while set all writes are blocked
   unknown encodings raise illegal_op and leave every strobe low */
`timescale 1ns/100ps

`include "id_params.svh"

module id_ctrl_decode import id_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  instr_u     instruction,
    input  logic       branch_taken,    // from the condition check
    output op_class_t  op_class,
    output reg_addr_t  read_addr1,
    output reg_addr_t  read_addr2,
    output reg_addr_t  write_addr,
    output logic       write_enable,
    output logic       write_data_sel,  // 1 = alu result, 0 = decoder value
    output logic       wr_cpsr,
    output logic       data_read,
    output logic       data_write,
    output logic       ir_op,           // 1 = register operand, 0 = immediate
    output logic       wr_pc,
    output logic       halt_flag,
    output logic       illegal_op,
    output logic [2:0] opcode
);

    logic [`ID_OP_MSB-`ID_OP_LSB:0] op_field;
    logic                           s_bit;
    logic                           we_dec;     // strobes before the halt gate
    logic                           cpsr_dec;
    logic                           rd_dec;
    logic                           wr_dec;
    logic                           pc_dec;
    logic                           halt_q;

    assign op_field = instruction.raw[`ID_OP_MSB:`ID_OP_LSB];
    assign s_bit    = instruction.raw[`ID_S_BIT];
    assign opcode   = op_field[2:0];            // alu function select

    always_comb begin
        case (op_field)
            `ID_ENC_LOAD:  op_class = OPC_LOAD;
            `ID_ENC_STOR:  op_class = OPC_STOR;
            `ID_ENC_MOV:   op_class = OPC_MOV;
            `ID_ENC_MOVT:  op_class = OPC_MOVT;
            `ID_ENC_ADD, `ID_ENC_ADDS, `ID_ENC_SUB, `ID_ENC_SUBS,
            `ID_ENC_AND, `ID_ENC_ANDS, `ID_ENC_OR, `ID_ENC_ORS,
            `ID_ENC_XOR, `ID_ENC_XORS:
                op_class = OPC_ALU_IMM;
            `ID_ENC_ADD2, `ID_ENC_ADDS2, `ID_ENC_SUB2, `ID_ENC_SUBS2,
            `ID_ENC_AND2, `ID_ENC_ANDS2, `ID_ENC_OR2, `ID_ENC_ORS2,
            `ID_ENC_XOR2, `ID_ENC_XORS2:
                op_class = OPC_ALU_REG;
            `ID_ENC_NOT:   op_class = OPC_NOT;
            `ID_ENC_LSL:   op_class = OPC_LSL;
            `ID_ENC_LSR:   op_class = OPC_LSR;
            `ID_ENC_CLR:   op_class = OPC_CLR;
            `ID_ENC_SET:   op_class = OPC_SET;
            `ID_ENC_B:     op_class = OPC_B;
            `ID_ENC_BCOND: op_class = OPC_BCOND;
            `ID_ENC_BR:    op_class = OPC_BR;
            `ID_ENC_NOP:   op_class = OPC_NOP;
            `ID_ENC_HALT:  op_class = OPC_HALT;
            default:       op_class = OPC_ILLEGAL;
        endcase
    end

    always_comb begin
        read_addr1     = '0;                    // unused addresses stay zero
        read_addr2     = '0;
        write_addr     = '0;
        we_dec         = 1'b0;
        write_data_sel = 1'b0;
        cpsr_dec       = 1'b0;
        rd_dec         = 1'b0;
        wr_dec         = 1'b0;
        ir_op          = 1'b0;
        pc_dec         = 1'b0;
        case (op_class)
            OPC_LOAD: begin
                write_addr = instruction.mem.rd;
                read_addr1 = instruction.mem.ptr;
                rd_dec     = 1'b1;
                we_dec     = 1'b1;
            end
            OPC_STOR: begin
                read_addr1 = instruction.mem.rd;    // value to store
                read_addr2 = instruction.mem.ptr;   // base pointer
                wr_dec     = 1'b1;
            end
            OPC_MOV, OPC_MOVT: begin
                read_addr1 = instruction.alu.rd;    // other half is kept
                write_addr = instruction.alu.rd;
                we_dec     = 1'b1;
            end
            OPC_ALU_IMM, OPC_ALU_REG: begin
                read_addr1     = instruction.alu.op1;
                write_addr     = instruction.alu.rd;
                write_data_sel = 1'b1;
                we_dec         = 1'b1;
                cpsr_dec       = s_bit;
                if (op_class == OPC_ALU_REG) begin
                    read_addr2 = instruction.alu.op2;
                    ir_op      = 1'b1;
                end
            end
            OPC_NOT: begin
                read_addr1     = instruction.alu.op1;
                write_addr     = instruction.alu.rd;
                write_data_sel = 1'b1;
                we_dec         = 1'b1;
            end
            OPC_LSL, OPC_LSR: begin
                read_addr1 = instruction.alu.op1;   // register being shifted
                write_addr = instruction.alu.rd;
                we_dec     = 1'b1;
            end
            OPC_CLR, OPC_SET: begin
                write_addr = instruction.alu.rd;
                we_dec     = 1'b1;
            end
            OPC_B:     pc_dec = 1'b1;
            OPC_BCOND: pc_dec = branch_taken;
            OPC_BR: begin
                read_addr1 = instruction.mem.rd;    // pointer in bits 24:22
                pc_dec     = 1'b1;
            end
            default: begin                          // nop, halt, illegal
            end
        endcase
    end

    // sticky halt, one edge after HALT is seen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt_q <= 1'b0;
        end else if (op_class == OPC_HALT) begin
            halt_q <= 1'b1;
        end
    end

    assign halt_flag    = halt_q;
    assign write_enable = we_dec & ~halt_q;
    assign wr_cpsr      = cpsr_dec & ~halt_q;
    assign data_read    = rd_dec & ~halt_q;
    assign data_write   = wr_dec & ~halt_q;
    assign wr_pc        = pc_dec & ~halt_q;
    assign illegal_op   = (op_class == OPC_ILLEGAL);

endmodule

// ==== hw/id_result_path.sv ====
/* data side of the decoder, purely combinational
   memory offsets and operand2 are zero-extended, branch offsets sign-extended
   the Bcond target is formed whether or not the branch is taken */
`timescale 1ns/100ps

module id_result_path import id_pkg::*; (
    input  instr_u    instruction,
    input  op_class_t op_class,
    input  word_t     reg1_val,
    input  word_t     reg2_val,
    input  word_t     data_val,     // data memory read value
    input  word_t     re_pc_val,
    output word_t     write_data,
    output word_t     operand2,
    output word_t     data_addr,
    output word_t     data_out,
    output word_t     id_pc_val
);

    word_t mem_off;
    word_t alu_imm;
    word_t br_off;

    assign mem_off = word_t'(instruction.mem.imm);                     // zero-extend
    assign alu_imm = word_t'(instruction.alu.imm);
    assign br_off  = word_t'(signed'(instruction.br.offset));          // sign-extend

    always_comb begin
        write_data = '0;
        operand2   = '0;
        data_addr  = '0;
        data_out   = '0;
        id_pc_val  = '0;
        case (op_class)
            OPC_LOAD: begin
                data_addr  = reg1_val + mem_off;
                write_data = data_val;
            end
            OPC_STOR: begin
                data_addr = reg2_val + mem_off;
                data_out  = reg1_val;
            end
            OPC_MOV:     write_data = {reg1_val[31:16], instruction.alu.imm};  // low half
            OPC_MOVT:    write_data = {instruction.alu.imm, reg1_val[15:0]};   // high half
            OPC_ALU_IMM: operand2   = alu_imm;
            OPC_LSL:     write_data = reg1_val << instruction.alu.imm;
            OPC_LSR:     write_data = reg1_val >> instruction.alu.imm;
            OPC_CLR:     write_data = '0;
            OPC_SET:     write_data = '1;
            OPC_B, OPC_BCOND: begin
                id_pc_val = re_pc_val + br_off;    // pc relative
            end
            OPC_BR:      id_pc_val  = reg1_val + br_off;   // register relative
            default: begin                          // alu reg, not, nop, halt, illegal
            end
        endcase
    end

endmodule

// ==== hw/id_top.sv ====
/* instruction decoder top, connects condition check, control decode and result path
   all outputs are combinational in the same cycle except halt_flag, which is registered */
`timescale 1ns/100ps

module id_top import id_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  word_t      instruction,     // from instruction memory
    input  word_t      reg1_val,
    input  word_t      reg2_val,
    input  word_t      data_val,
    input  word_t      re_cpsr_val,
    input  word_t      re_pc_val,
    output reg_addr_t  read_addr1,
    output reg_addr_t  read_addr2,
    output reg_addr_t  write_addr,
    output logic       write_enable,
    output logic       write_data_sel,
    output logic       wr_cpsr,
    output logic       data_read,
    output logic       data_write,
    output logic       ir_op,
    output logic       wr_pc,
    output logic       halt_flag,
    output logic       illegal_op,
    output logic [2:0] opcode,
    output word_t      write_data,
    output word_t      operand2,
    output word_t      data_addr,
    output word_t      data_out,
    output word_t      id_pc_val
);

    instr_u    instr_w;                 // same word, field views
    op_class_t op_class;
    logic      branch_taken;

    assign instr_w = instruction;

    id_cond_check u_cond (
        .cond         (instr_w.br.cond),
        .cpsr_val     (re_cpsr_val),
        .branch_taken (branch_taken)
    );

    id_ctrl_decode u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .instruction    (instr_w),
        .branch_taken   (branch_taken),
        .op_class       (op_class),
        .read_addr1     (read_addr1),
        .read_addr2     (read_addr2),
        .write_addr     (write_addr),
        .write_enable   (write_enable),
        .write_data_sel (write_data_sel),
        .wr_cpsr        (wr_cpsr),
        .data_read      (data_read),
        .data_write     (data_write),
        .ir_op          (ir_op),
        .wr_pc          (wr_pc),
        .halt_flag      (halt_flag),
        .illegal_op     (illegal_op),
        .opcode         (opcode)
    );

    id_result_path u_result (
        .instruction (instr_w),
        .op_class    (op_class),
        .reg1_val    (reg1_val),
        .reg2_val    (reg2_val),
        .data_val    (data_val),
        .re_pc_val   (re_pc_val),
        .write_data  (write_data),
        .operand2    (operand2),
        .data_addr   (data_addr),
        .data_out    (data_out),
        .id_pc_val   (id_pc_val)
    );

endmodule

// ==== verif/id_clk_gen.sv ====
/* free-running testbench clock, starts low
   the first rising edge comes half a period after time zero */
`timescale 1ns/100ps

module id_clk_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;  // 50 % duty
    end

endmodule

// ==== verif/id_tb.sv ====
/* table-driven testbench of the decoder, one row per cycle, driven on the falling edge
   outputs are sampled 4 ns after the falling edge, just before the next rising edge
   expected values come from the per-class rules of the builder tasks below */
`timescale 1ns/100ps

`include "id_params.svh"

module id_tb;

    localparam int ROWS_MAX   = 64;
    localparam int RST_CYCLES = 8;
    localparam int S_WE   = 7;      // bit positions in the expected strobe vector
    localparam int S_SEL  = 6;
    localparam int S_CPSR = 5;
    localparam int S_DRD  = 4;
    localparam int S_DWR  = 3;
    localparam int S_IROP = 2;
    localparam int S_PC   = 1;
    localparam int S_ILL  = 0;
    localparam logic [7:0] GATED = 8'b1011_1010;   // strobes blocked while halted

    logic        clk;
    logic        arst_n;
    logic [31:0] instruction, reg1_val, reg2_val, data_val, re_cpsr_val, re_pc_val;
    logic [2:0]  read_addr1, read_addr2, write_addr, opcode;
    logic        write_enable, write_data_sel, wr_cpsr, data_read, data_write;
    logic        ir_op, wr_pc, halt_flag, illegal_op;
    logic [31:0] write_data, operand2, data_addr, data_out, id_pc_val;

    // stimulus columns
    logic [31:0] t_instr [ROWS_MAX];
    logic [31:0] t_r1    [ROWS_MAX];
    logic [31:0] t_r2    [ROWS_MAX];
    logic [31:0] t_dv    [ROWS_MAX];
    logic [31:0] t_cpsr  [ROWS_MAX];
    logic [31:0] t_pc    [ROWS_MAX];
    logic        t_rst   [ROWS_MAX];    // reset pulse before the row
    // expected columns
    logic [2:0]  x_ra1   [ROWS_MAX];
    logic [2:0]  x_ra2   [ROWS_MAX];
    logic [2:0]  x_wa    [ROWS_MAX];
    logic [2:0]  x_opc   [ROWS_MAX];
    logic [7:0]  x_str   [ROWS_MAX];
    logic        x_halt  [ROWS_MAX];
    logic        x_chkpc [ROWS_MAX];    // target only checked when meaningful
    logic [31:0] x_wd    [ROWS_MAX];
    logic [31:0] x_op2   [ROWS_MAX];
    logic [31:0] x_da    [ROWS_MAX];
    logic [31:0] x_do    [ROWS_MAX];
    logic [31:0] x_pc    [ROWS_MAX];

    integer seed;
    int     n_rows      = 0;
    int     cur_row     = 0;
    int     err_cnt     = 0;
    int     cycle_cnt   = 0;
    int     cycle_limit = 1000;         // replaced once the table is built
    logic   halted      = 1'b0;         // HALT seen since the last reset
    logic   pending_rst = 1'b0;

    id_clk_gen #(.PERIOD_NS(10.0)) u_clk (.clk(clk));

    id_top u_id_top (
        .clk(clk), .arst_n(arst_n), .instruction(instruction),
        .reg1_val(reg1_val), .reg2_val(reg2_val), .data_val(data_val),
        .re_cpsr_val(re_cpsr_val), .re_pc_val(re_pc_val),
        .read_addr1(read_addr1), .read_addr2(read_addr2), .write_addr(write_addr),
        .write_enable(write_enable), .write_data_sel(write_data_sel), .wr_cpsr(wr_cpsr),
        .data_read(data_read), .data_write(data_write), .ir_op(ir_op), .wr_pc(wr_pc),
        .halt_flag(halt_flag), .illegal_op(illegal_op), .opcode(opcode),
        .write_data(write_data), .operand2(operand2), .data_addr(data_addr),
        .data_out(data_out), .id_pc_val(id_pc_val)
    );

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic start_row(input logic [31:0] instr);
        t_instr[n_rows] = instr;
        t_r1[n_rows]    = $random(seed);
        t_r2[n_rows]    = $random(seed);
        t_dv[n_rows]    = $random(seed);
        t_cpsr[n_rows]  = $random(seed);
        t_pc[n_rows]    = $random(seed);
        t_rst[n_rows]   = pending_rst;
        pending_rst     = 1'b0;
        x_ra1[n_rows]   = '0;               // unused addresses read as zero
        x_ra2[n_rows]   = '0;
        x_wa[n_rows]    = '0;
        x_opc[n_rows]   = instr[27:25];     // low three bits of the op field
        x_str[n_rows]   = '0;
        x_halt[n_rows]  = halted;
        x_chkpc[n_rows] = 1'b1;
        x_wd[n_rows]    = '0;
        x_op2[n_rows]   = '0;
        x_da[n_rows]    = '0;
        x_do[n_rows]    = '0;
        x_pc[n_rows]    = '0;
    endtask

    task automatic end_row();
        if (halted) begin
            x_str[n_rows] = x_str[n_rows] & ~GATED;
        end
        n_rows = n_rows + 1;
    endtask

    // mode 0 immediate form, 1 register form, 2 NOT
    task automatic add_alu(input logic [6:0] enc, input int mode);
        logic [2:0]  rd;
        logic [2:0]  o1;
        logic [2:0]  o2;
        logic [15:0] imm;
        rd  = $random(seed);
        o1  = $random(seed);
        o2  = $random(seed);
        imm = $random(seed);
        start_row({enc, rd, o1, o2, imm});
        x_ra1[n_rows]         = o1;
        x_wa[n_rows]          = rd;
        x_str[n_rows][S_WE]   = 1'b1;
        x_str[n_rows][S_SEL]  = 1'b1;
        x_str[n_rows][S_CPSR] = enc[3];     // S bit
        if (mode == 0) begin
            x_op2[n_rows] = {16'h0, imm};
        end else if (mode == 1) begin
            x_ra2[n_rows]         = o2;
            x_str[n_rows][S_IROP] = 1'b1;
        end
        end_row();
    endtask

    task automatic add_mem(input logic is_load);
        logic [2:0]  rd;
        logic [2:0]  ptr;
        logic [15:0] imm;
        rd  = $random(seed);
        ptr = $random(seed);
        imm = $random(seed);
        if (is_load) begin
            start_row({`ID_ENC_LOAD, rd, ptr, 3'b000, imm});
            x_ra1[n_rows]        = ptr;
            x_wa[n_rows]         = rd;
            x_str[n_rows][S_WE]  = 1'b1;
            x_str[n_rows][S_DRD] = 1'b1;
            x_da[n_rows]         = t_r1[n_rows] + {16'h0, imm};
            x_wd[n_rows]         = t_dv[n_rows];
        end else begin
            start_row({`ID_ENC_STOR, rd, ptr, 3'b000, imm});
            x_ra1[n_rows]        = rd;
            x_ra2[n_rows]        = ptr;
            x_str[n_rows][S_DWR] = 1'b1;
            x_da[n_rows]         = t_r2[n_rows] + {16'h0, imm};
            x_do[n_rows]         = t_r1[n_rows];
        end
        end_row();
    endtask

    // register writes whose value is formed in the decoder
    task automatic add_wr(input logic [6:0] enc, input logic [15:0] imm);
        logic [2:0] rd;
        logic [2:0] o1;
        rd = $random(seed);
        o1 = $random(seed);
        start_row({enc, rd, o1, 3'b000, imm});
        x_wa[n_rows]        = rd;
        x_str[n_rows][S_WE] = 1'b1;
        case (enc)
            `ID_ENC_MOV: begin
                x_ra1[n_rows] = rd;
                x_wd[n_rows]  = {t_r1[n_rows][31:16], imm};
            end
            `ID_ENC_MOVT: begin
                x_ra1[n_rows] = rd;
                x_wd[n_rows]  = {imm, t_r1[n_rows][15:0]};
            end
            `ID_ENC_LSL: begin
                x_ra1[n_rows] = o1;
                x_wd[n_rows]  = t_r1[n_rows] << imm;
            end
            `ID_ENC_LSR: begin
                x_ra1[n_rows] = o1;
                x_wd[n_rows]  = t_r1[n_rows] >> imm;
            end
            `ID_ENC_SET: x_wd[n_rows] = 32'hffff_ffff;
            default:     x_wd[n_rows] = 32'h0;          // CLR
        endcase
        end_row();
    endtask

    task automatic add_jump(input logic is_reg);
        logic [2:0]  ptr;
        logic [15:0] off;
        ptr = $random(seed);
        off = $random(seed);
        if (is_reg) begin
            start_row({`ID_ENC_BR, ptr, 6'b0, off});
            x_ra1[n_rows] = ptr;
            x_pc[n_rows]  = t_r1[n_rows] + sext16(off);
        end else begin
            start_row({`ID_ENC_B, 4'b0000, 5'b0, off});
            x_pc[n_rows]  = t_pc[n_rows] + sext16(off);
        end
        x_str[n_rows][S_PC] = 1'b1;
        end_row();
    endtask

    task automatic add_bcond(input logic [3:0] cond, input logic [3:0] nzcv, input logic taken);
        logic [15:0] off;
        off = $random(seed);
        start_row({`ID_ENC_BCOND, cond, 5'b0, off});
        t_cpsr[n_rows][31:28] = nzcv;       // n z c v
        x_str[n_rows][S_PC]   = taken;
        x_chkpc[n_rows]       = taken;
        x_pc[n_rows]          = t_pc[n_rows] + sext16(off);
        end_row();
    endtask

    task automatic add_plain(input logic [31:0] instr, input logic ill);
        start_row(instr);
        x_str[n_rows][S_ILL] = ill;
        end_row();
    endtask

    task automatic build_table();
        int f;
        int s;
        int rf;
        add_plain({`ID_ENC_NOP, 25'h0}, 1'b0);          // first row after reset
        for (f = 1; f <= 5; f++) begin
            for (s = 0; s <= 1; s++) begin
                for (rf = 0; rf <= 1; rf++) begin
                    add_alu({1'b0, rf[0], 1'b1, s[0], f[2:0]}, rf);
                end
            end
        end
        add_alu(`ID_ENC_NOT, 2);
        add_mem(1'b1);
        add_mem(1'b0);
        add_wr(`ID_ENC_MOV, 16'hbeef);
        add_wr(`ID_ENC_MOVT, 16'h5a5a);
        add_wr(`ID_ENC_LSL, 16'd7);
        add_wr(`ID_ENC_LSR, 16'd19);
        add_wr(`ID_ENC_CLR, 16'h0);
        add_wr(`ID_ENC_SET, 16'h0);
        add_jump(1'b0);
        add_jump(1'b1);
        add_bcond(`ID_COND_EQ, 4'b0100, 1'b1);
        add_bcond(`ID_COND_NE, 4'b0100, 1'b0);
        add_bcond(`ID_COND_CS, 4'b0010, 1'b1);
        add_bcond(`ID_COND_CC, 4'b0010, 1'b0);
        add_bcond(`ID_COND_MI, 4'b1000, 1'b1);
        add_bcond(`ID_COND_PL, 4'b1000, 1'b0);
        add_bcond(`ID_COND_VS, 4'b0000, 1'b0);
        add_bcond(`ID_COND_VC, 4'b0000, 1'b1);
        add_bcond(`ID_COND_HI, 4'b0010, 1'b1);
        add_bcond(`ID_COND_HI, 4'b0110, 1'b0);
        add_bcond(`ID_COND_LS, 4'b0110, 1'b1);
        add_bcond(`ID_COND_LS, 4'b0010, 1'b0);
        add_bcond(`ID_COND_GE, 4'b1100, 1'b1);          // N equal to Z
        add_bcond(`ID_COND_GE, 4'b1000, 1'b0);
        add_bcond(`ID_COND_LT, 4'b0100, 1'b1);
        add_bcond(`ID_COND_LT, 4'b0000, 1'b0);
        add_plain({7'b1111111, 25'h0}, 1'b1);           // no such encoding
        add_plain({`ID_ENC_NOP, 25'h0}, 1'b0);
        add_plain({`ID_ENC_HALT, 25'h0}, 1'b0);
        halted = 1'b1;                                  // flag visible from next row on
        add_alu(`ID_ENC_ADDS2, 1);
        add_mem(1'b1);                                  // data and pc strobes held low too
        add_mem(1'b0);
        add_jump(1'b0);
        pending_rst = 1'b1;
        halted      = 1'b0;
        add_alu(`ID_ENC_ADDS, 0);
        add_mem(1'b1);
    endtask

    task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp) begin
            $display("** Error at %0t ns: row %0d %s is %h, expected %h",
                     $time, cur_row, what, act, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_row(input int r);
        check_eq(read_addr1, x_ra1[r], "read_addr1");
        check_eq(read_addr2, x_ra2[r], "read_addr2");
        check_eq(write_addr, x_wa[r], "write_addr");
        check_eq(opcode, x_opc[r], "opcode");
        check_eq(write_enable, x_str[r][S_WE], "write_enable");
        check_eq(write_data_sel, x_str[r][S_SEL], "write_data_sel");
        check_eq(wr_cpsr, x_str[r][S_CPSR], "wr_cpsr");
        check_eq(data_read, x_str[r][S_DRD], "data_read");
        check_eq(data_write, x_str[r][S_DWR], "data_write");
        check_eq(ir_op, x_str[r][S_IROP], "ir_op");
        check_eq(wr_pc, x_str[r][S_PC], "wr_pc");
        check_eq(illegal_op, x_str[r][S_ILL], "illegal_op");
        check_eq(halt_flag, x_halt[r], "halt_flag");
        check_eq(write_data, x_wd[r], "write_data");
        check_eq(operand2, x_op2[r], "operand2");
        check_eq(data_addr, x_da[r], "data_addr");
        check_eq(data_out, x_do[r], "data_out");
        if (x_chkpc[r]) begin
            check_eq(id_pc_val, x_pc[r], "id_pc_val");
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(negedge clk);
        arst_n = 1'b0;
        repeat (cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the table did not complete", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        arst_n      = 1'b0;
        instruction = {`ID_ENC_NOP, 25'h0};
        reg1_val    = '0;
        reg2_val    = '0;
        data_val    = '0;
        re_cpsr_val = '0;
        re_pc_val   = '0;
        seed        = 15050;
        build_table();
        cycle_limit = n_rows + RST_CYCLES + 20;
        apply_reset(RST_CYCLES);
        for (int i = 0; i < n_rows; i++) begin
            if (t_rst[i]) begin
                apply_reset(2);             // second reset clears the halt
            end
            @(negedge clk);
            instruction = t_instr[i];
            reg1_val    = t_r1[i];
            reg2_val    = t_r2[i];
            data_val    = t_dv[i];
            re_cpsr_val = t_cpsr[i];
            re_pc_val   = t_pc[i];
            #4;                             // settle before the rising edge
            cur_row = i;
            check_row(i);
        end
        $display("rows applied: %0d, errors: %0d", n_rows, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/id_pkg.sv
hw/id_cond_check.sv
hw/id_ctrl_decode.sv
hw/id_result_path.sv
hw/id_top.sv
verif/id_clk_gen.sv
verif/id_tb.sv

// ==== Bender.yml ====
package:
  name: id_decoder

sources:
  - include_dirs:
      - hw
    files:
      - hw/id_pkg.sv
      - hw/id_cond_check.sv
      - hw/id_ctrl_decode.sv
      - hw/id_result_path.sv
      - hw/id_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/id_clk_gen.sv
      - verif/id_tb.sv
